// File: fp_sqrt_top.f
verilog/fp_sqrt_pkg.sv
verilog/fp_sqrt_unpack.sv
verilog/int_sqrt.sv
verilog/fp_sqrt_pack.sv
verilog/fp_sqrt_top.sv
verif/fp_sqrt_asserts.sv
verif/fp_sqrt_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fp_sqrt testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module fp_sqrt_tb -f fp_sqrt_top.f > sim.log 2>&1 &&
   ./obj_dir/Vfp_sqrt_tb >> sim.log 2>&1 ||
   echo "build or simulation error" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "%Error" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

// File: verif/fp_sqrt_tb.sv
`default_nettype none

module fp_sqrt_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DATA_W  = 32;
   localparam int EXP_W   = 8;
   localparam int MAN_W   = DATA_W - EXP_W;
   localparam int FRAC_W  = MAN_W - 1;
   localparam int BIAS    = 2**(EXP_W-1) - 1;
   localparam int LATENCY = MAN_W + 3;
   localparam int TIMEOUT = 4 * LATENCY;

   typedef struct packed {
      logic              exc;
      logic [DATA_W-1:0] res;
   } sqrt_result_t;

   logic              clk_i;
   logic              rst_i;
   logic              start_i;
   logic [DATA_W-1:0] op_i;
   logic              done_o;
   logic [DATA_W-1:0] res_o;
   logic              exception_o;

   logic [31:0] rng_state;
   int          n_tests;
   int          n_failed;
   int          n_errors;
   int          test_errors;   // errors in the running test

   // exact squares and their roots, odd and even exponents
   logic [DATA_W-1:0] square_ops[7]   = '{32'h3F800000, 32'h40800000, 32'h3E800000,
                                          32'h49800000, 32'h40100000, 32'h41100000,
                                          32'h3F100000};
   logic [DATA_W-1:0] square_roots[7] = '{32'h3F800000, 32'h40000000, 32'h3F000000,
                                          32'h44800000, 32'h3FC00000, 32'h40400000,
                                          32'h3F400000};

   fp_sqrt_top #(.DATA_W(DATA_W), .EXP_W(EXP_W)) UUT (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .start_i     (start_i),
      .op_i        (op_i),
      .done_o      (done_o),
      .res_o       (res_o),
      .exception_o (exception_o)
   );

   always #20 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // largest r with r*r <= value, built from the top bit down
   function automatic logic [63:0] floor_sqrt(input logic [63:0] value, input int bits);
      logic [63:0] r;
      logic [63:0] cand;
      r = '0;
      for (int b = bits - 1; b >= 0; b--) begin
         cand = r | (64'd1 << b);
         if (cand * cand <= value) r = cand;
      end
      return r;
   endfunction

   function automatic sqrt_result_t model_sqrt(input logic [DATA_W-1:0] op);
      sqrt_result_t     exp_r;
      int               exp_field;
      int               e_unb;
      int               e_half;
      int               lead;
      logic [63:0]      rad;
      logic [63:0]      root;
      logic [MAN_W-1:0] man;
      logic [FRAC_W-1:0] frac;
      exp_r     = '0;
      exp_field = int'(op[DATA_W-2 -: EXP_W]);
      if (exp_field == 0) return exp_r;   // zero and denormals
      if (op[DATA_W-1]) begin
         exp_r.exc = 1'b1;
         return exp_r;
      end
      e_unb = exp_field - BIAS;
      man   = {1'b1, op[FRAC_W-1:0]};
      rad   = (e_unb % 2 != 0) ? 64'(man) : (64'(man) << 1);
      root  = floor_sqrt(rad << MAN_W, MAN_W + 1);
      lead  = 0;
      for (int b = 0; b < 64; b++) begin
         if (root[b]) lead = b;
      end
      frac   = FRAC_W'(root >> (lead - FRAC_W));   // bits just below the leading one
      e_half = (e_unb < 0) ? -((1 - e_unb) / 2) : e_unb / 2;   // floor of e/2
      exp_r.res = {1'b0, EXP_W'(e_half + BIAS), frac};
      return exp_r;
   endfunction

   task automatic check_value(input string name, input logic [DATA_W-1:0] op,
                              input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s = %h, expected %h (op_i %h)", name, got, exp, op);
         test_errors++;
      end
   endtask

   task automatic issue_start(input logic [DATA_W-1:0] op);
      @(negedge clk_i);
      start_i = 1'b1;
      op_i    = op;
      @(negedge clk_i);
      start_i = 1'b0;
      check_value("done_o", op, DATA_W'(done_o), '0);
   endtask

   // counts rising edges from the start edge until done_o is seen high
   task automatic wait_done(output int edges);
      edges = 0;
      while (!done_o && edges < TIMEOUT) begin
         @(negedge clk_i);
         edges++;
      end
      if (!done_o) begin
         $display("timeout: done_o did not rise within %0d cycles of start", TIMEOUT);
         $display("TEST FAIL");
         $finish;
      end
   endtask

   task automatic check_outcome(input logic [DATA_W-1:0] op, input int edges);
      sqrt_result_t exp_r;
      exp_r = model_sqrt(op);
      assert (edges == LATENCY) else begin
         $display("done_o rose %0d cycles after start instead of %0d (op_i %h)",
                  edges, LATENCY, op);
         test_errors++;
      end
      check_value("res_o", op, res_o, exp_r.res);
      check_value("exception_o", op, DATA_W'(exception_o), DATA_W'(exp_r.exc));
   endtask

   task automatic run_and_check(input logic [DATA_W-1:0] op);
      int edges;
      issue_start(op);
      wait_done(edges);
      check_outcome(op, edges);
   endtask

   task automatic end_test(input string name);
      n_tests++;
      if (test_errors == 0) begin
         $display("test %-10s ok", name);
      end else begin
         $display("test %-10s failed with %0d errors", name, test_errors);
         n_failed++;
         n_errors += test_errors;
      end
      test_errors = 0;
   endtask

   initial begin
      logic [31:0]       rnd;
      logic [DATA_W-1:0] op;
      int                edges;
      int                delay;
      clk_i       = 1'b0;
      rst_i       = 1'b1;
      start_i     = 1'b0;
      op_i        = '0;
      rng_state   = 32'd2797;
      n_tests     = 0;
      n_failed    = 0;
      n_errors    = 0;
      test_errors = 0;

      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      @(negedge clk_i);
      check_value("done_o", op_i, DATA_W'(done_o), DATA_W'(1));
      check_value("res_o", op_i, res_o, '0);
      check_value("exception_o", op_i, DATA_W'(exception_o), '0);
      end_test("reset");

      for (int i = 0; i < 7; i++) begin
         run_and_check(square_ops[i]);
         check_value("res_o", square_ops[i], res_o, square_roots[i]);
      end
      end_test("squares");

      for (int i = 0; i < 300; i++) begin
         rnd = next_random();
         op  = {1'b0, EXP_W'(1 + rnd % 254), FRAC_W'(next_random())};   // no exp 0 or 255
         run_and_check(op);
      end
      end_test("random");

      run_and_check(32'h00000000);
      run_and_check(32'h80000000);
      run_and_check(32'h00012345);   // denormal
      run_and_check(32'h80400000);
      run_and_check(32'hC0800000);   // -4.0
      for (int i = 0; i < 20; i++) begin
         rnd = next_random();
         run_and_check({1'b1, EXP_W'(1 + rnd % 254), FRAC_W'(next_random())});
      end
      end_test("special");

      // second start early, then right before the first result
      for (int k = 0; k < 2; k++) begin
         delay = (k == 0) ? 9 : 24;
         issue_start(32'h40490FDB);
         repeat (delay) begin
            @(negedge clk_i);
            check_value("done_o", op_i, DATA_W'(done_o), '0);
         end
         rnd = next_random();
         op  = {1'b0, EXP_W'(1 + rnd % 254), FRAC_W'(next_random())};
         issue_start(op);
         wait_done(edges);
         check_outcome(op, edges);
      end
      end_test("restart");

      $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
      if (n_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/fp_sqrt_asserts.sv
`default_nettype none

module fp_sqrt_asserts #(
   parameter  int DATA_W = 32,
   parameter  int EXP_W  = 8,
   localparam int MAN_W  = DATA_W - EXP_W
) (
   input logic              clk_i,
   input logic              rst_i,
   input logic              start_i,
   input logic              done_o,
   input logic [DATA_W-1:0] res_o,
   input logic              exception_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int LATENCY = MAN_W + 3;

   logic busy;          // an operation is in flight
   int   since_start;   // edges since the start edge

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy        <= 1'b0;
         since_start <= 0;
      end else if (start_i) begin
         busy        <= 1'b1;   // restart resets the count
         since_start <= 0;
      end else if (busy) begin
         if (since_start == LATENCY) begin
            busy <= 1'b0;
         end else begin
            since_start <= since_start + 1;
         end
      end
   end

   assert property (@(posedge clk_i) disable iff (rst_i) start_i |=> !done_o)
      else $error("done_o did not fall on the edge after start_i");

   // done stays low until the last edge of the latency, then rises
   assert property (@(posedge clk_i) disable iff (rst_i)
      (busy && since_start < LATENCY) |-> !done_o)
      else $error("done_o rose before the full latency");

   assert property (@(posedge clk_i) disable iff (rst_i)
      (busy && since_start == LATENCY) |-> done_o)
      else $error("done_o did not rise at the expected edge");

   assert property (@(posedge clk_i) disable iff (rst_i)
      (done_o && $past(done_o)) |-> ($stable(res_o) && $stable(exception_o)))
      else $error("result changed while done_o stayed high");

   assert property (@(posedge clk_i) disable iff (rst_i) exception_o |-> (res_o == '0))
      else $error("exception_o set with a nonzero result");

endmodule

bind fp_sqrt_top fp_sqrt_asserts #(
   .DATA_W (DATA_W),
   .EXP_W  (EXP_W)
) u_asserts (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .start_i     (start_i),
   .done_o      (done_o),
   .res_o       (res_o),
   .exception_o (exception_o)
);

`default_nettype wire

// File: verilog/fp_sqrt_top.sv
`default_nettype none

module fp_sqrt_top
   import fp_sqrt_pkg::*;
#(
   parameter  int DATA_W = 32,
   parameter  int EXP_W  = 8,
   localparam int MAN_W  = DATA_W - EXP_W
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              start_i,
   input  logic [DATA_W-1:0] op_i,
   output logic              done_o,
   output logic [DATA_W-1:0] res_o,
   output logic              exception_o
);

   logic             root_start;
   logic [MAN_W+1:0] radicand;
   sqrt_ctrl_t       ctrl;
   logic [EXP_W-1:0] half_exp;
   logic             root_valid;
   logic [MAN_W:0]   root;

   fp_sqrt_unpack #(.DATA_W(DATA_W), .EXP_W(EXP_W)) u_unpack (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start_i),
      .op_i         (op_i),
      .root_start_o (root_start),
      .radicand_o   (radicand),
      .ctrl_o       (ctrl),
      .half_exp_o   (half_exp)
   );

   // (MAN_W+2 + MAN_W)/2 = MAN_W+1 root bits
   int_sqrt #(.DATA_W(MAN_W + 2), .FRACTIONAL_W(MAN_W)) u_int_sqrt (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .start_i (root_start),
      .op_i    (radicand),
      .done_o  (root_valid),
      .res_o   (root)
   );

   fp_sqrt_pack #(.DATA_W(DATA_W), .EXP_W(EXP_W)) u_pack (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start_i),
      .root_valid_i (root_valid),
      .root_i       (root),
      .ctrl_i       (ctrl),
      .half_exp_i   (half_exp),
      .res_o        (res_o),
      .exception_o  (exception_o),
      .done_o       (done_o)
   );

endmodule

`default_nettype wire

// File: verilog/fp_sqrt_pack.sv
`default_nettype none

module fp_sqrt_pack
   import fp_sqrt_pkg::*;
#(
   parameter  int DATA_W = 32,
   parameter  int EXP_W  = 8,
   localparam int MAN_W  = DATA_W - EXP_W
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              start_i,
   input  logic              root_valid_i,
   input  logic [MAN_W:0]    root_i,
   input  sqrt_ctrl_t        ctrl_i,
   input  logic [EXP_W-1:0]  half_exp_i,
   output logic [DATA_W-1:0] res_o,
   output logic              exception_o,
   output logic              done_o
);

   logic             start_q;
   logic             accept;
   logic [MAN_W-2:0] frac;

   // a root finishing right around a restart belongs to the aborted op
   assign accept = root_valid_i & ~start_i & ~start_q;

   // drop the leading one, its position depends on exponent parity
   assign frac = ctrl_i.exp_odd ? root_i[MAN_W-2:0] : root_i[MAN_W-1:1];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         start_q     <= 1'b0;
         done_o      <= 1'b1;   // idle reads as done
         res_o       <= '0;
         exception_o <= 1'b0;
      end else begin
         start_q <= start_i;

         if (start_i) begin
            done_o <= 1'b0;
         end else if (accept) begin
            done_o <= 1'b1;
         end

         if (accept) begin
            exception_o <= (ctrl_i.op_class == CLS_NEGATIVE);
            if (ctrl_i.op_class == CLS_NORMAL) begin
               res_o <= {1'b0, half_exp_i, frac};   // sign always positive
            end else begin
               res_o <= '0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/int_sqrt.sv
`default_nettype none

module int_sqrt #(
   parameter  int DATA_W       = 32,
   parameter  int FRACTIONAL_W = 8,
   localparam int RES_W        = (DATA_W + FRACTIONAL_W) / 2
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              start_i,
   input  logic [DATA_W-1:0] op_i,
   output logic              done_o,
   output logic [RES_W-1:0]  res_o
);

   // radicand is scaled by 2^FRACTIONAL_W, sum of widths assumed even
   localparam int RAD_W = DATA_W + FRACTIONAL_W;
   localparam int REM_W = RES_W + 2;
   localparam int CNT_W = $clog2(RES_W);

   typedef enum logic {
      IDLE,
      RUN
   } state_e;

   state_e           state;
   logic [CNT_W-1:0] cnt;        // root bits still to decide, minus one
   logic [RAD_W-1:0] rad;
   logic [REM_W-1:0] rem;
   logic [REM_W-1:0] rem_shift;
   logic [REM_W-1:0] trial;
   logic             fits;

   // bring down the next two radicand bits
   assign rem_shift = {rem[REM_W-3:0], rad[RAD_W-1 -: 2]};
   assign trial     = {res_o, 2'b01};   // 4*root + 1
   assign fits      = (rem_shift >= trial);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state  <= IDLE;
         cnt    <= '0;
         done_o <= 1'b0;
      end else if (start_i) begin
         // restart even when busy
         state  <= RUN;
         cnt    <= CNT_W'(RES_W - 1);
         done_o <= 1'b0;
      end else if (state == RUN) begin
         if (cnt == '0) begin
            state  <= IDLE;
            done_o <= 1'b1;   // last bit decided
         end else begin
            cnt <= cnt - 1'b1;
         end
      end else begin
         done_o <= 1'b0;
      end
   end

   // restoring step, one root bit per cycle
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         rad   <= RAD_W'(op_i) << FRACTIONAL_W;
         rem   <= '0;
         res_o <= '0;
      end else if (state == RUN) begin
         rad   <= rad << 2;
         rem   <= fits ? (rem_shift - trial) : rem_shift;
         res_o <= {res_o[RES_W-2:0], fits};
      end
   end

endmodule

`default_nettype wire

// File: verilog/fp_sqrt_unpack.sv
`default_nettype none

module fp_sqrt_unpack
   import fp_sqrt_pkg::*;
#(
   parameter  int DATA_W = 32,
   parameter  int EXP_W  = 8,
   localparam int MAN_W  = DATA_W - EXP_W
) (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               start_i,
   input  logic [DATA_W-1:0]  op_i,
   output logic               root_start_o,
   output logic [MAN_W+1:0]   radicand_o,
   output sqrt_ctrl_t         ctrl_o,
   output logic [EXP_W-1:0]   half_exp_o
);

   localparam int BIAS = 2**(EXP_W-1) - 1;

   logic [EXP_W-1:0] exp_field;
   logic [MAN_W-1:0] mantissa;
   logic [EXP_W-1:0] exp_unb;
   operand_class_e   op_class;

   assign exp_field = op_i[DATA_W-2 -: EXP_W];
   assign mantissa  = {1'b1, op_i[MAN_W-2:0]};   // hidden bit restored
   assign exp_unb   = exp_field - EXP_W'(BIAS);

   always_comb begin
      if (exp_field == '0) begin
         op_class = CLS_ZERO;   // denormals flushed too
      end else if (op_i[DATA_W-1]) begin
         op_class = CLS_NEGATIVE;
      end else begin
         op_class = CLS_NORMAL;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         root_start_o <= 1'b0;
         ctrl_o       <= '{op_class: CLS_ZERO, exp_odd: 1'b0};
      end else begin
         root_start_o <= start_i;   // kicks the root one cycle later
         if (start_i) begin
            ctrl_o.op_class <= op_class;
            ctrl_o.exp_odd  <= exp_unb[0];
         end
      end
   end

   // odd exponent keeps the mantissa low, even one shifts it up a bit
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         radicand_o <= exp_unb[0] ? {2'b00, mantissa} : {1'b0, mantissa, 1'b0};
         half_exp_o <= {exp_unb[EXP_W-1], exp_unb[EXP_W-1:1]} + EXP_W'(BIAS);
      end
   end

endmodule

`default_nettype wire

// File: verilog/fp_sqrt_pkg.sv
`default_nettype none

package fp_sqrt_pkg;

   // operand class as seen by the input side
   typedef enum logic [1:0] {
      CLS_ZERO,      // zero exponent, flushed
      CLS_NORMAL,
      CLS_NEGATIVE   // nonzero with sign set
   } operand_class_e;

   // control info carried from unpack to pack
   typedef struct packed {
      operand_class_e op_class;
      logic           exp_odd;   // unbiased exponent is odd
   } sqrt_ctrl_t;

endpackage

`default_nettype wire
